//--- source/scaler_params.svh
`ifndef SCALER_PARAMS_SVH
`define SCALER_PARAMS_SVH

// Bits per grayscale pixel.
`define PIXEL_WIDTH 8

// Pixels per row held in one line buffer bank.
`define LINE_MAX 64

// Bits of a width, a height or a row/column index.
`define RESO_WIDTH 12

// Signed step accumulator, one bit wider than a size.
`define ACC_WIDTH 13

`endif

//--- source/video_pkg.sv
`include "scaler_params.svh"

package video_pkg;

	// Column bits of a line buffer address.
	localparam int LB_COL_WIDTH = $clog2(`LINE_MAX);

	// One grayscale pixel value.
	typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

	// Frame width, height, or a row/column index.
	typedef logic [`RESO_WIDTH-1:0] reso_t;

	// Line buffer address: bank bit on top, column below.
	typedef logic [LB_COL_WIDTH:0] lb_addr_t;

endpackage

//--- source/scaler_pkg.sv
`include "scaler_params.svh"

package scaler_pkg;

	// Bresenham error term, negative while no source step is due.
	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

	typedef enum logic [1:0] {
		W_IDLE,  // Waiting for tuser.
		W_ROW,   // Taking pixels of a row.
		W_HOLD,  // Next bank still in use by the reader.
		W_DRAIN  // All rows written, output frame still running.
	} writer_state_t;

	typedef enum logic [1:0] {
		R_IDLE,
		R_WAIT_ROW,
		R_EMIT,
		R_LAST
	} reader_state_t;

endpackage

//--- source/axis_if.sv
`timescale 1ns/1ns
`include "scaler_params.svh"

interface axis_if;

	video_pkg::pixel_t tdata;
	logic tuser;   // First pixel of a frame.
	logic tlast;   // Last pixel of a row.
	logic tvalid;
	logic tready;

	modport source (
		output tdata,
		output tuser,
		output tlast,
		output tvalid,
		input  tready
	);

	modport sink (
		input  tdata,
		input  tuser,
		input  tlast,
		input  tvalid,
		output tready
	);

endinterface

//--- source/linebuffer.sv
`timescale 1ns/1ns
`include "scaler_params.svh"

module linebuffer (
	input  logic                clk,
	input  logic                wr_en,
	input  video_pkg::lb_addr_t wr_addr,
	input  video_pkg::pixel_t   wr_data,
	input  video_pkg::lb_addr_t rd_addr,
	output video_pkg::pixel_t   rd_data
);

	// Two banks of LINE_MAX pixels, bank selected by row parity.
	video_pkg::pixel_t mem [2*`LINE_MAX];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr]; // One cycle read latency.
	end

endmodule

//--- source/row_writer.sv
`timescale 1ns/1ns
`include "scaler_params.svh"

module row_writer (
	input  logic                clk,
	input  logic                resetn,
	axis_if.sink                s_axis,
	input  video_pkg::reso_t    s_width,
	input  video_pkg::reso_t    s_height,
	input  video_pkg::reso_t    row_needed,
	input  logic                frame_busy,
	output logic                wr_en,
	output video_pkg::lb_addr_t wr_addr,
	output video_pkg::pixel_t   wr_data,
	output video_pkg::reso_t    rows_done
);

	scaler_pkg::writer_state_t state, state_nxt;
	video_pkg::reso_t col, row, sw, sh;
	video_pkg::reso_t cur_col, cur_row, cur_w, cur_h;
	logic ready_q;
	logic take;
	logic row_end;
	logic last_row;
	logic row_complete;

	// In IDLE the tuser beat is column 0 of row 0 with the live sizes.
	assign cur_col = (state == scaler_pkg::W_IDLE) ? '0 : col;
	assign cur_row = (state == scaler_pkg::W_IDLE) ? '0 : row;
	assign cur_w = (state == scaler_pkg::W_IDLE) ? s_width : sw;
	assign cur_h = (state == scaler_pkg::W_IDLE) ? s_height : sh;

	assign take = s_axis.tvalid && ready_q && (state == scaler_pkg::W_ROW || s_axis.tuser);
	assign row_end = (cur_col == cur_w - 1'b1);
	assign last_row = (cur_row == cur_h - 1'b1);

	assign s_axis.tready = ready_q;
	assign wr_en = take;
	assign wr_addr = {cur_row[0], cur_col[video_pkg::LB_COL_WIDTH-1:0]};
	assign wr_data = s_axis.tdata;

	always_comb begin
		state_nxt = state;
		case (state)
			scaler_pkg::W_IDLE, scaler_pkg::W_ROW: begin
				if (take && row_end) begin
					if (last_row) begin
						state_nxt = scaler_pkg::W_DRAIN;
					end else if (cur_row <= row_needed) begin
						state_nxt = scaler_pkg::W_ROW; // Next bank already free.
					end else begin
						state_nxt = scaler_pkg::W_HOLD;
					end
				end else if (take) begin
					state_nxt = scaler_pkg::W_ROW;
				end
			end
			scaler_pkg::W_HOLD: begin
				if (row <= row_needed + 1'b1) begin
					state_nxt = scaler_pkg::W_ROW;
				end
			end
			scaler_pkg::W_DRAIN: begin
				// Wait until the last row count is visible and the output frame ended.
				if (rows_done == sh && !frame_busy) begin
					state_nxt = scaler_pkg::W_IDLE;
				end
			end
			default: state_nxt = scaler_pkg::W_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= scaler_pkg::W_IDLE;
			ready_q <= 1'b0;
			row_complete <= 1'b0;
			rows_done <= '0;
			col <= '0;
			row <= '0;
			sw <= '0;
			sh <= '0;
		end else begin
			state <= state_nxt;
			ready_q <= (state_nxt == scaler_pkg::W_IDLE) || (state_nxt == scaler_pkg::W_ROW);
			row_complete <= take && row_end;
			if (row_complete) begin
				rows_done <= rows_done + 1'b1; // Count lags the tlast position by a cycle.
			end
			if (take) begin
				if (row_end) begin
					col <= '0;
					row <= cur_row + 1'b1;
				end else begin
					col <= cur_col + 1'b1;
					row <= cur_row;
				end
			end
			if (take && state == scaler_pkg::W_IDLE) begin
				sw <= s_width;
				sh <= s_height;
				rows_done <= '0; // Frame start seen by the reader.
			end
		end
	end

endmodule

//--- source/row_resampler.sv
`timescale 1ns/1ns
`include "scaler_params.svh"

module row_resampler (
	input  logic                clk,
	input  logic                resetn,
	input  video_pkg::reso_t    m_width,
	input  video_pkg::reso_t    m_height,
	input  video_pkg::reso_t    s_width,
	input  video_pkg::reso_t    s_height,
	input  video_pkg::reso_t    rows_done,
	output video_pkg::lb_addr_t rd_addr,
	input  video_pkg::pixel_t   rd_data,
	output video_pkg::reso_t    row_needed,
	output logic                frame_busy,
	axis_if.source              m_axis
);

	scaler_pkg::reader_state_t state;
	video_pkg::reso_t mw, mh, sw, sh;
	video_pkg::reso_t x, y, sx, sy;
	scaler_pkg::acc_t acc_x, acc_y;
	logic v1, u1, l1;
	logic v2, u2, l2;
	video_pkg::pixel_t buf_data [2];
	logic buf_user [2];
	logic buf_last [2];
	logic wptr, rptr;
	logic [1:0] cnt;
	logic [2:0] held;
	logic pop, room, step_x, issue, load;

	assign pop = m_axis.tvalid && m_axis.tready;
	// Beats in flight plus buffered must never exceed the two skid entries.
	assign held = 3'(cnt) + 3'(v1) + 3'(v2) - 3'(pop);
	assign room = (held < 3'd2);
	assign step_x = !acc_x[`ACC_WIDTH-1]; // Source column still behind.
	assign issue = (state == scaler_pkg::R_EMIT) && !step_x && room;

	// rows_done at zero marks a frame start; sizes are stable from then on.
	assign load = (rows_done == '0) && (state == scaler_pkg::R_IDLE ||
		(state == scaler_pkg::R_WAIT_ROW && y == '0));

	assign row_needed = sy;
	assign m_axis.tvalid = (cnt != 2'd0);
	assign m_axis.tdata = buf_data[rptr];
	assign m_axis.tuser = buf_user[rptr];
	assign m_axis.tlast = buf_last[rptr];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= scaler_pkg::R_IDLE;
			frame_busy <= 1'b0;
			v1 <= 1'b0;
			v2 <= 1'b0;
			cnt <= 2'd0;
			wptr <= 1'b0;
			rptr <= 1'b0;
			x <= '0;
			y <= '0;
			sx <= '0;
			sy <= '0;
			acc_x <= '0;
			acc_y <= '0;
			mw <= '0;
			mh <= '0;
			sw <= '0;
			sh <= '0;
		end else begin
			v1 <= issue;
			v2 <= v1;
			cnt <= cnt + 2'(v2) - 2'(pop);
			if (v2) begin
				wptr <= ~wptr;
			end
			if (pop) begin
				rptr <= ~rptr;
			end
			if (load) begin
				mw <= m_width;
				mh <= m_height;
				sw <= s_width;
				sh <= s_height;
				acc_x <= -scaler_pkg::acc_t'({1'b0, m_width});
				acc_y <= -scaler_pkg::acc_t'({1'b0, m_height});
				x <= '0;
				y <= '0;
				sx <= '0;
				sy <= '0;
				frame_busy <= 1'b1;
				state <= scaler_pkg::R_WAIT_ROW;
			end else begin
				case (state)
					scaler_pkg::R_WAIT_ROW: begin
						if (!acc_y[`ACC_WIDTH-1]) begin
							acc_y <= acc_y - scaler_pkg::acc_t'({1'b0, mh});
							sy <= sy + 1'b1; // Frees the bank of the old row.
						end else if (y == mh) begin
							state <= scaler_pkg::R_LAST;
						end else if (sy < rows_done) begin
							state <= scaler_pkg::R_EMIT;
						end
					end
					scaler_pkg::R_EMIT: begin
						if (step_x) begin
							acc_x <= acc_x - scaler_pkg::acc_t'({1'b0, mw});
							sx <= sx + 1'b1;
						end else if (room) begin
							if (x == mw - 1'b1) begin
								x <= '0;
								sx <= '0;
								acc_x <= -scaler_pkg::acc_t'({1'b0, mw});
								y <= y + 1'b1;
								acc_y <= acc_y + scaler_pkg::acc_t'({1'b0, sh});
								state <= scaler_pkg::R_WAIT_ROW;
							end else begin
								x <= x + 1'b1;
								acc_x <= acc_x + scaler_pkg::acc_t'({1'b0, sw});
							end
						end
					end
					scaler_pkg::R_LAST: begin
						if (cnt == 2'd0 && !v1 && !v2) begin
							frame_busy <= 1'b0;
							state <= scaler_pkg::R_IDLE;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			rd_addr <= {sy[0], sx[video_pkg::LB_COL_WIDTH-1:0]};
			u1 <= (x == '0) && (y == '0);
			l1 <= (x == mw - 1'b1);
		end
		u2 <= u1;
		l2 <= l1;
		if (v2) begin
			buf_data[wptr] <= rd_data;
			buf_user[wptr] <= u2;
			buf_last[wptr] <= l2;
		end
	end

endmodule

//--- source/axis_scaler.sv
`timescale 1ns/1ns
`include "scaler_params.svh"

module axis_scaler (
	input  logic              clk,
	input  logic              resetn,
	input  video_pkg::pixel_t s_axis_tdata,
	input  logic              s_axis_tuser,
	input  logic              s_axis_tlast,
	input  logic              s_axis_tvalid,
	output logic              s_axis_tready,
	output video_pkg::pixel_t m_axis_tdata,
	output logic              m_axis_tuser,
	output logic              m_axis_tlast,
	output logic              m_axis_tvalid,
	input  logic              m_axis_tready,
	input  video_pkg::reso_t  s_width,
	input  video_pkg::reso_t  s_height,
	input  video_pkg::reso_t  m_width,
	input  video_pkg::reso_t  m_height
);

	axis_if s_if ();
	axis_if m_if ();

	video_pkg::reso_t    rows_done;
	video_pkg::reso_t    row_needed;
	logic                frame_busy;
	logic                wr_en;
	video_pkg::lb_addr_t wr_addr;
	video_pkg::pixel_t   wr_data;
	video_pkg::lb_addr_t rd_addr;
	video_pkg::pixel_t   rd_data;

	assign s_if.tdata = s_axis_tdata;
	assign s_if.tuser = s_axis_tuser;
	assign s_if.tlast = s_axis_tlast;
	assign s_if.tvalid = s_axis_tvalid;
	assign s_axis_tready = s_if.tready;

	assign m_axis_tdata = m_if.tdata;
	assign m_axis_tuser = m_if.tuser;
	assign m_axis_tlast = m_if.tlast;
	assign m_axis_tvalid = m_if.tvalid;
	assign m_if.tready = m_axis_tready;

	row_writer writer_i (
		.clk        (clk),
		.resetn     (resetn),
		.s_axis     (s_if.sink),
		.s_width    (s_width),
		.s_height   (s_height),
		.row_needed (row_needed),
		.frame_busy (frame_busy),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rows_done  (rows_done)
	);

	linebuffer linebuffer_i (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	row_resampler resampler_i (
		.clk        (clk),
		.resetn     (resetn),
		.m_width    (m_width),
		.m_height   (m_height),
		.s_width    (s_width),
		.s_height   (s_height),
		.rows_done  (rows_done),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.row_needed (row_needed),
		.frame_busy (frame_busy),
		.m_axis     (m_if.source)
	);

endmodule

//--- verification/axis_scaler_assertions.sv
`timescale 1ns/1ns
`include "scaler_params.svh"

module axis_scaler_assertions (
	input logic              clk,
	input logic              resetn,
	input logic              s_axis_tready,
	input video_pkg::pixel_t m_axis_tdata,
	input logic              m_axis_tvalid,
	input logic              m_axis_tready
);

	// A stalled output beat keeps its valid and its data.
	stall_holds_beat: assert property (
		@(posedge clk) disable iff (!resetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
	) else $error("m_axis beat changed while stalled");

	// Checked from the second reset cycle on once the registers are cleared.
	no_valid_in_reset: assert property (
		@(posedge clk)
		(!resetn ##1 !resetn) |-> !m_axis_tvalid
	) else $error("m_axis_tvalid high during reset");

	no_ready_in_reset: assert property (
		@(posedge clk)
		(!resetn ##1 !resetn) |-> !s_axis_tready
	) else $error("s_axis_tready high during reset");

endmodule

//--- verification/axis_scaler_tb.sv
`timescale 1ns/1ns
`include "scaler_params.svh"

module axis_scaler_tb;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 16;
	localparam int SEED = 60449;
	localparam int MAX_SRC_H = 16;
	localparam int MAX_OUT_W = 96;
	localparam int MAX_OUT_H = 24;
	localparam int NUM_DIRECTED = 6;
	localparam int NUM_RANDOM = 20;
	localparam int NUM_FRAMES = NUM_DIRECTED + NUM_RANDOM;
	localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * MAX_OUT_W * MAX_OUT_H * 8 * CLK_PERIOD
		+ longint'(RESET_CYCLES) * CLK_PERIOD;

	logic clk;
	logic resetn_tb;
	video_pkg::pixel_t s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	logic s_axis_tready;
	video_pkg::pixel_t m_axis_tdata;
	logic m_axis_tuser;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready;
	video_pkg::reso_t s_width;
	video_pkg::reso_t s_height;
	video_pkg::reso_t m_width;
	video_pkg::reso_t m_height;

	video_pkg::pixel_t src_mem [`LINE_MAX*MAX_SRC_H];
	video_pkg::pixel_t exp_data [$];
	logic exp_user [$];
	logic exp_last [$];
	video_pkg::pixel_t want_data;
	logic want_user;
	logic want_last;
	int stall_pct;
	int gap_pct;
	int error_count;
	int beats_seen;
	int beats_expected;
	int frames_done;

	axis_scaler dut_i (
		.clk           (clk),
		.resetn        (resetn_tb),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.s_width       (s_width),
		.s_height      (s_height),
		.m_width       (m_width),
		.m_height      (m_height)
	);

	bind axis_scaler axis_scaler_assertions assertions_i (
		.clk           (clk),
		.resetn        (resetn),
		.s_axis_tready (s_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Offers one input beat after a random gap and holds it until taken.
	task automatic send_pixel(input video_pkg::pixel_t data, input logic user, input logic last);
		logic accepted;
		while ($urandom_range(99, 0) < gap_pct) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		s_axis_tdata = data;
		s_axis_tuser = user;
		s_axis_tlast = last;
		s_axis_tvalid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = s_axis_tready; // Transfer happens on the next rising edge.
			@(posedge clk);
			#DRIVE_DELAY;
		end
		s_axis_tvalid = 1'b0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	// Sends one source frame and waits until its whole output frame is seen.
	task automatic run_frame(input int sw, input int sh, input int mw, input int mh,
		input int stall, input int gap);
		int src_x;
		int src_y;
		stall_pct = stall;
		gap_pct = gap;
		s_width = video_pkg::reso_t'(sw);
		s_height = video_pkg::reso_t'(sh);
		m_width = video_pkg::reso_t'(mw);
		m_height = video_pkg::reso_t'(mh);
		for (int i = 0; i < sw * sh; i++) begin
			src_mem[i] = video_pkg::pixel_t'($urandom);
		end
		for (int y = 0; y < mh; y++) begin
			for (int x = 0; x < mw; x++) begin
				src_y = (y * sh) / mh; // Nearest neighbour rounds down.
				src_x = (x * sw) / mw;
				exp_data.push_back(src_mem[src_y * sw + src_x]);
				exp_user.push_back(x == 0 && y == 0);
				exp_last.push_back(x == mw - 1);
			end
		end
		beats_expected += mw * mh;
		for (int y = 0; y < sh; y++) begin
			for (int x = 0; x < sw; x++) begin
				send_pixel(src_mem[y * sw + x], x == 0 && y == 0, x == sw - 1);
			end
		end
		wait (beats_seen == beats_expected);
		@(posedge clk);
		#DRIVE_DELAY;
		frames_done++;
	endtask

	// Output monitor samples mid-cycle where all signals are settled.
	always @(negedge clk) begin
		if (resetn_tb && m_axis_tvalid && m_axis_tready) begin
			if (exp_data.size() == 0) begin
				error_count++;
				$display("Error at %0t ns: output beat arrived when none was expected", $time);
			end else begin
				want_data = exp_data.pop_front();
				want_user = exp_user.pop_front();
				want_last = exp_last.pop_front();
				if (m_axis_tdata !== want_data) begin
					error_count++;
					$display("Error at %0t ns: m_axis_tdata = 0x%h, expected 0x%h (beat %0d)",
						$time, m_axis_tdata, want_data, beats_seen);
				end
				if (m_axis_tuser !== want_user) begin
					error_count++;
					$display("Error at %0t ns: m_axis_tuser = %b, expected %b (beat %0d)",
						$time, m_axis_tuser, want_user, beats_seen);
				end
				if (m_axis_tlast !== want_last) begin
					error_count++;
					$display("Error at %0t ns: m_axis_tlast = %b, expected %b (beat %0d)",
						$time, m_axis_tlast, want_last, beats_seen);
				end
				beats_seen++;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout at %0t ns: output frames stopped, %0d of %0d frames done, errors: %0d",
			$time, frames_done, NUM_FRAMES, error_count);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int sw;
		int sh;
		int mw;
		int mh;
		void'($urandom(SEED));
		resetn_tb = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		s_width = video_pkg::reso_t'(8);
		s_height = video_pkg::reso_t'(6);
		m_width = video_pkg::reso_t'(8);
		m_height = video_pkg::reso_t'(6);
		stall_pct = 0;
		gap_pct = 0;
		error_count = 0;
		beats_seen = 0;
		beats_expected = 0;
		frames_done = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		resetn_tb = 1'b1;
		fork
			forever begin
				@(posedge clk);
				#DRIVE_DELAY;
				m_axis_tready = ($urandom_range(99, 0) >= stall_pct);
			end
		join_none
		run_frame(8, 6, 8, 6, 0, 0); // Identity at full rate.
		run_frame(`LINE_MAX, 16, `LINE_MAX, 16, 30, 20);
		run_frame(10, 10, 15, 15, 25, 25);
		run_frame(40, 12, 13, 1, 20, 10); // Height shrinks to one row.
		run_frame(`LINE_MAX, 16, 5, 3, 40, 30);
		run_frame(1, 1, MAX_OUT_W, MAX_OUT_H, 10, 0);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			sw = $urandom_range(`LINE_MAX, 1);
			sh = $urandom_range(MAX_SRC_H, 1);
			mw = $urandom_range(MAX_OUT_W, 1);
			mh = $urandom_range(MAX_OUT_H, 1);
			run_frame(sw, sh, mw, mh, $urandom_range(60, 0), $urandom_range(50, 0));
		end
		stall_pct = 0;
		repeat (50) @(posedge clk); // Any extra beat shows up here.
		if (exp_data.size() != 0) begin
			error_count++;
			$display("Error: %0d expected output beats were never sent", exp_data.size());
		end
		$display("Frames: %0d, beats checked: %0d, errors: %0d",
			frames_done, beats_seen, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- axis_scaler.f
+incdir+source
source/video_pkg.sv
source/scaler_pkg.sv
source/axis_if.sv
source/linebuffer.sv
source/row_writer.sv
source/row_resampler.sv
source/axis_scaler.sv
verification/axis_scaler_assertions.sv
verification/axis_scaler_tb.sv
